// File: sim.f
common/sdram_pkg.sv
sdram_ctrl/sdram_ctrl.sv
sdram_model/sdram_model.sv
design/sdram_subsys_top.sv
dv/tb_clkgen.sv
dv/sdram_subsys_sva.sv
dv/sdram_subsys_tb.sv

// File: Bender.yml
package:
  name: sdram_subsys

sources:
  # RTL, needed for both the design and the dv target
  - target: any(design, dv)
    files:
      - common/sdram_pkg.sv
      - sdram_ctrl/sdram_ctrl.sv
      - sdram_model/sdram_model.sv
      - design/sdram_subsys_top.sv

  # testbench, clock generator and bound assertions
  - target: dv
    files:
      - dv/tb_clkgen.sv
      - dv/sdram_subsys_sva.sv
      - dv/sdram_subsys_tb.sv

// File: dv/sdram_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_subsys_tb import sdram_pkg::*; ();

  localparam int ROW_BITS         = 6;
  localparam int COL_BITS         = 5;
  localparam int CAS_LATENCY      = 3;
  localparam int REFRESH_INTERVAL = 64;
  localparam int INIT_WAIT        = 20;
  localparam int ADR_W            = BANK_BITS + ROW_BITS + COL_BITS - 1;

  localparam int N_FULL     = 40;
  localparam int N_SEL      = 12;
  localparam int N_ALIAS    = 8;
  localparam int N_GAP      = 3;
  localparam int N_B2B      = 8;
  localparam int N_ACCESS   = 2 + 2*N_FULL + 3*N_SEL + 2*N_ALIAS + 2*N_GAP + 2*N_B2B;
  localparam int MAX_CYCLES = 200 + 30 * N_ACCESS;

  logic             clk;
  logic             reset;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [ADR_W-1:0] wb_adr;
  logic [31:0]      wb_dat_w;
  logic [3:0]       wb_sel;
  logic [31:0]      wb_dat_r;
  logic             wb_ack;

  logic [31:0]      shadow [0:(1<<ADR_W)-1];   // expected memory, by word address
  logic [31:0]      rng;
  logic [ADR_W-1:0] adr_list [$];
  int               cycle;
  int               n_pass;
  int               n_fail;
  int               n_access;
  int               ack_count;

  tb_clkgen #(
    .PERIOD_NS    (10),
    .RESET_CYCLES (4)
  ) u_clkgen (
    .clk   (clk),
    .reset (reset)
  );

  sdram_subsys_top #(
    .ROW_BITS         (ROW_BITS),
    .COL_BITS         (COL_BITS),
    .CAS_LATENCY      (CAS_LATENCY),
    .REFRESH_INTERVAL (REFRESH_INTERVAL),
    .INIT_WAIT        (INIT_WAIT)
  ) u_dut (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_sel   (wb_sel),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // bytes with sel set take the new data
  function automatic logic [31:0] expected_word(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  sel);
    logic [31:0] merged;
    for (int b = 0; b < 4; b++) begin
      merged[b*8 +: 8] = sel[b] ? new_word[b*8 +: 8] : old_word[b*8 +: 8];
    end
    return merged;
  endfunction

  function automatic logic [ADR_W-1:0] make_adr(input int bank, input int row, input int colp);
    return {BANK_BITS'(bank), ROW_BITS'(row), (COL_BITS-1)'(colp)};
  endfunction

  // starts 1 ns after an edge, returns 1 ns after the edge that takes the ack
  task automatic access(input logic we, input logic [ADR_W-1:0] adr, input logic [31:0] data,
                        input logic [3:0] sel, input bit keep);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = data;
    wb_sel   = sel;
    n_access++;
    @(negedge clk);
    while (wb_ack !== 1'b1) @(negedge clk);
    @(posedge clk);
    #1;
    if (!keep) begin   // keep means the next request follows at once
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
    end
  endtask

  task automatic write_word(input logic [ADR_W-1:0] adr, input logic [31:0] data,
                            input logic [3:0] sel, input bit keep);
    access(1'b1, adr, data, sel, keep);
  endtask

  task automatic read_word(input logic [ADR_W-1:0] adr, input bit keep);
    access(1'b0, adr, 32'h0, 4'hf, keep);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic report_test(input string name, input int fails_before);
    if (n_fail == fails_before) $display("test %-22s ok", name);
    else $display("test %-22s %0d errors", name, n_fail - fails_before);
  endtask

  // compare process, sampled mid cycle while the master still holds the request
  always @(negedge clk) begin
    if (wb_ack === 1'b1) begin
      ack_count++;
      if (wb_we) begin
        shadow[wb_adr] = expected_word(shadow[wb_adr], wb_dat_w, wb_sel);
      end else if (wb_dat_r !== shadow[wb_adr]) begin
        $display("[ERROR] %0t ns: read at %h expected %h got %h",
                 $time, wb_adr, shadow[wb_adr], wb_dat_r);
        n_fail++;
      end else begin
        n_pass++;
      end
    end
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle >= MAX_CYCLES) begin
      $display("run timed out after %0d cycles, an access was never acknowledged", cycle);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    logic [ADR_W-1:0] adr;
    logic [31:0]      data;
    int               fails_before;
    int               start_cycle;
    int               latency;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    wb_sel    = '0;
    rng       = 32'd55339;
    cycle     = 0;
    n_pass    = 0;
    n_fail    = 0;
    n_access  = 0;
    ack_count = 0;
    for (int i = 0; i < (1 << ADR_W); i++) begin
      shadow[i] = 'x;
    end

    // reset, then a write held from the first cycle through init
    fails_before = n_fail;
    @(negedge clk);
    while (reset) begin
      if (wb_ack !== 1'b0) begin
        $display("[ERROR] %0t ns: wb_ack is %b during reset", $time, wb_ack);
        n_fail++;
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    adr         = ADR_W'(next_rand());
    start_cycle = cycle;
    write_word(adr, next_rand(), 4'hf, 1'b0);
    latency = cycle - start_cycle;
    if (latency < INIT_WAIT + 6) begin
      $display("first write acked after %0d cycles, before init could finish", latency);
      n_fail++;
    end else begin
      n_pass++;
    end
    read_word(adr, 1'b0);
    report_test("reset and first access", fails_before);

    fails_before = n_fail;
    adr_list.delete();
    for (int i = 0; i < N_FULL; i++) begin
      adr = ADR_W'(next_rand());
      adr_list.push_back(adr);
      write_word(adr, next_rand(), 4'hf, 1'b0);
    end
    foreach (adr_list[i]) read_word(adr_list[i], 1'b0);
    report_test("full words", fails_before);

    // prewrite, then partial writes over the same words
    fails_before = n_fail;
    adr_list.delete();
    for (int i = 0; i < N_SEL; i++) begin
      adr = ADR_W'(next_rand());
      adr_list.push_back(adr);
      write_word(adr, next_rand(), 4'hf, 1'b0);
    end
    foreach (adr_list[i]) write_word(adr_list[i], next_rand(), 4'(next_rand()), 1'b0);
    foreach (adr_list[i]) read_word(adr_list[i], 1'b0);
    report_test("byte selects", fails_before);

    // top byte tags each location so no two values match
    fails_before = n_fail;
    adr_list.delete();
    for (int b = 0; b < 4; b++) begin
      data        = next_rand();
      data[31:24] = 8'hb0 + 8'(b);
      adr_list.push_back(make_adr(b, 5, 7));
      write_word(adr_list[$], data, 4'hf, 1'b0);
    end
    for (int k = 0; k < N_ALIAS - 4; k++) begin
      data        = next_rand();
      data[31:24] = 8'hc0 + 8'(k);
      adr_list.push_back(make_adr(2, 9 + 13 * k, 7));
      write_word(adr_list[$], data, 4'hf, 1'b0);
    end
    foreach (adr_list[i]) read_word(adr_list[i], 1'b0);
    report_test("bank and row aliasing", fails_before);

    fails_before = n_fail;
    adr_list.delete();
    for (int i = 0; i < N_GAP; i++) begin
      adr = ADR_W'(next_rand());
      adr_list.push_back(adr);
      write_word(adr, next_rand(), 4'hf, 1'b0);
      idle_cycles(REFRESH_INTERVAL + 10);   // at least one refresh in every gap
    end
    foreach (adr_list[i]) begin
      read_word(adr_list[i], 1'b0);
      idle_cycles(REFRESH_INTERVAL + 10);
    end
    adr_list.delete();
    for (int i = 0; i < N_B2B; i++) begin
      adr = ADR_W'(next_rand());
      adr_list.push_back(adr);
      write_word(adr, next_rand(), 4'hf, 1'b1);
    end
    foreach (adr_list[i]) read_word(adr_list[i], i != N_B2B - 1);
    if (ack_count != n_access) begin
      $display("[ERROR] %0t ns: %0d acks seen for %0d accesses", $time, ack_count, n_access);
      n_fail++;
    end else begin
      n_pass++;
    end
    report_test("refresh and back to back", fails_before);

    if (u_dut.u_ctrl.u_sva.sva_errors != 0) begin
      $display("%0d bound assertion failures were reported", u_dut.u_ctrl.u_sva.sva_errors);
      n_fail++;
    end
    $display("checks: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/sdram_subsys_sva.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_subsys_sva import sdram_pkg::*; (
  input logic                 clk,
  input logic                 reset,
  input logic                 wb_cyc,
  input logic                 wb_stb,
  input logic                 wb_ack,
  input logic                 sd_cs,
  input logic                 sd_ras,
  input logic                 sd_cas,
  input logic                 sd_we,
  input logic [12:0]          sd_a,
  input logic [BANK_BITS-1:0] sd_ba,
  input ctrl_state_e          state
);

  logic [3:0]                cmd;
  logic [(1<<BANK_BITS)-1:0] open_banks;   // banks with an ACTIVE not yet precharged
  logic                      init_done;
  int                        sva_errors = 0;

  assign cmd = {sd_cs, sd_ras, sd_cas, sd_we};

  always_ff @(posedge clk) begin
    if (reset) begin
      open_banks <= '0;
      init_done  <= 1'b0;
    end else begin
      if (state == ST_IDLE) init_done <= 1'b1;
      if (cmd == CMD_ACTIVE) begin
        open_banks[sd_ba] <= 1'b1;
      end else if (cmd == CMD_PRECHARGE) begin
        if (sd_a[10]) open_banks <= '0;   // precharge all
        else open_banks[sd_ba] <= 1'b0;
      end
    end
  end

  ack_with_request: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> wb_cyc && wb_stb)
    else begin
      $error("wb_ack high without cyc and stb");
      sva_errors++;
    end

  ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack)
    else begin
      $error("wb_ack held for two cycles");
      sva_errors++;
    end

  access_to_open_bank: assert property (@(posedge clk) disable iff (reset)
    (cmd == CMD_READ || cmd == CMD_WRITE) |-> open_banks[sd_ba])
    else begin
      $error("READ or WRITE to bank %0d without ACTIVE", sd_ba);
      sva_errors++;
    end

  // no bus traffic finishes before the init sequence reached idle
  ack_after_init: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> init_done)
    else begin
      $error("wb_ack before init finished");
      sva_errors++;
    end

endmodule

bind sdram_ctrl sdram_subsys_sva u_sva (
  .clk    (clk),
  .reset  (reset),
  .wb_cyc (wb_cyc),
  .wb_stb (wb_stb),
  .wb_ack (wb_ack),
  .sd_cs  (sd_cs),
  .sd_ras (sd_ras),
  .sd_cas (sd_cas),
  .sd_we  (sd_we),
  .sd_a   (sd_a),
  .sd_ba  (sd_ba),
  .state  (state)
);

`default_nettype wire

// File: dv/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // reset drops just after an edge, like the rest of the stimulus
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// File: design/sdram_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_subsys_top import sdram_pkg::*; #(
  parameter int ROW_BITS         = 6,
  parameter int COL_BITS         = 5,
  parameter int CAS_LATENCY      = 3,
  parameter int REFRESH_INTERVAL = 64,
  parameter int INIT_WAIT        = 20
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   wb_cyc,
  input  logic                                   wb_stb,
  input  logic                                   wb_we,
  input  logic [BANK_BITS+ROW_BITS+COL_BITS-2:0] wb_adr,
  input  logic [BURST_LEN*DQ_BITS-1:0]           wb_dat_w,
  input  logic [BURST_LEN*DQ_BITS/8-1:0]         wb_sel,
  output logic [BURST_LEN*DQ_BITS-1:0]           wb_dat_r,
  output logic                                   wb_ack
);

  // internal SDRAM bus
  wire                 sd_cke;
  wire                 sd_cs;
  wire                 sd_ras;
  wire                 sd_cas;
  wire                 sd_we;
  wire [12:0]          sd_a;
  wire [BANK_BITS-1:0] sd_ba;
  wire [DQ_BITS/8-1:0] sd_dqm;
  wire [DQ_BITS-1:0]   sd_dq;

  sdram_ctrl #(
    .ROW_BITS         (ROW_BITS),
    .COL_BITS         (COL_BITS),
    .CAS_LATENCY      (CAS_LATENCY),
    .REFRESH_INTERVAL (REFRESH_INTERVAL),
    .INIT_WAIT        (INIT_WAIT)
  ) u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_sel   (wb_sel),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .sd_cke   (sd_cke),
    .sd_cs    (sd_cs),
    .sd_ras   (sd_ras),
    .sd_cas   (sd_cas),
    .sd_we    (sd_we),
    .sd_a     (sd_a),
    .sd_ba    (sd_ba),
    .sd_dqm   (sd_dqm),
    .sd_dq    (sd_dq)
  );

  // CAS latency reaches the device through the mode register
  sdram_model #(
    .ROW_BITS (ROW_BITS),
    .COL_BITS (COL_BITS)
  ) u_mem (
    .clk (clk),
    .cke (sd_cke),
    .cs  (sd_cs),
    .ras (sd_ras),
    .cas (sd_cas),
    .we  (sd_we),
    .a   (sd_a),
    .ba  (sd_ba),
    .dqm (sd_dqm),
    .dq  (sd_dq)
  );

endmodule

`default_nettype wire

// File: sdram_model/sdram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_model import sdram_pkg::*; #(
  parameter int ROW_BITS = 6,
  parameter int COL_BITS = 5
) (
  input  wire                 clk,
  input  wire                 cke,
  input  wire                 cs,
  input  wire                 ras,
  input  wire                 cas,
  input  wire                 we,
  input  wire [12:0]          a,
  input  wire [BANK_BITS-1:0] ba,
  input  wire [DQ_BITS/8-1:0] dqm,
  inout  wire [DQ_BITS-1:0]   dq
);

  localparam int NBANK  = 1 << BANK_BITS;
  localparam int MEM_AW = BANK_BITS + ROW_BITS + COL_BITS;

  logic [DQ_BITS-1:0] mem [0:(1 << MEM_AW)-1];   // {bank, row, col}

  logic [2:0] cas_latency;
  logic [3:0] burst_len;     // 1, 2, 4 or 8

  logic [ROW_BITS-1:0] active_row [0:NBANK-1];
  logic [NBANK-1:0]    bank_open;

  logic                 burst_active;
  logic                 burst_write;
  logic [BANK_BITS-1:0] burst_bank;
  logic [ROW_BITS-1:0]  burst_row;   // held so a precharge mid burst is harmless
  logic [COL_BITS-1:0]  burst_col;
  logic [3:0]           burst_cnt;
  logic [2:0]           rd_wait;

  logic [DQ_BITS-1:0] dq_out;
  logic               dq_oe;

  sdram_cmd_e        cmd;
  logic              wr_en;
  logic [MEM_AW-1:0] wr_idx;
  logic [MEM_AW-1:0] burst_idx;

  // column wraps inside the aligned burst block
  function automatic logic [COL_BITS-1:0] wrap_col(input logic [COL_BITS-1:0] start,
                                                   input logic [3:0] offs,
                                                   input logic [3:0] len);
    logic [COL_BITS-1:0] mask;
    mask = COL_BITS'(len - 4'd1);
    return (start & ~mask) | ((start + COL_BITS'(offs)) & mask);
  endfunction

  assign cmd       = cs ? CMD_DESELECT : sdram_cmd_e'({cs, ras, cas, we});
  assign burst_idx = {burst_bank, burst_row, wrap_col(burst_col, burst_cnt, burst_len)};

  assign dq = dq_oe ? dq_out : 'z;

  // beat 0 of a write comes with the command, the rest from the burst engine
  always_comb begin
    wr_en  = 1'b0;
    wr_idx = burst_idx;
    if (cke) begin
      if (cmd == CMD_WRITE && bank_open[ba]) begin
        wr_en  = 1'b1;
        wr_idx = {ba, active_row[ba], a[COL_BITS-1:0]};
      end else if (burst_active && burst_write) begin
        wr_en = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < DQ_BITS / 8; b++) begin
        if (!dqm[b]) mem[wr_idx][b*8 +: 8] <= dq[b*8 +: 8];   // dqm high masks the byte
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cke) begin
      // burst engine first, so a new command overrides it
      if (burst_active) begin
        if (burst_write) begin
          burst_cnt <= burst_cnt + 4'd1;
          if (burst_cnt == burst_len - 4'd1) burst_active <= 1'b0;
        end else if (rd_wait != 3'd0) begin
          rd_wait <= rd_wait - 3'd1;
        end else begin
          dq_oe     <= 1'b1;
          dq_out    <= mem[burst_idx];
          burst_cnt <= burst_cnt + 4'd1;
          if (burst_cnt == burst_len - 4'd1) burst_active <= 1'b0;
        end
      end else begin
        dq_oe <= 1'b0;   // release the bus between bursts
      end

      case (cmd)
        CMD_LOAD_MODE: begin
          cas_latency <= a[MODE_CL_LSB +: 3];
          burst_len   <= 4'd1 << a[MODE_BL_LSB +: 2];
        end
        CMD_ACTIVE: begin
          active_row[ba] <= a[ROW_BITS-1:0];
          bank_open[ba]  <= 1'b1;
        end
        CMD_PRECHARGE: begin
          if (a[10]) bank_open <= '0;
          else bank_open[ba] <= 1'b0;
        end
        CMD_READ, CMD_WRITE: begin
          if (bank_open[ba]) begin
            burst_active <= (cmd == CMD_READ) || (burst_len > 4'd1);
            burst_write  <= (cmd == CMD_WRITE);
            burst_bank   <= ba;
            burst_row    <= active_row[ba];
            burst_col    <= a[COL_BITS-1:0];
            burst_cnt    <= (cmd == CMD_WRITE) ? 4'd1 : 4'd0;
            rd_wait      <= cas_latency - 3'd2;   // output register adds one cycle
          end else begin
            $error("sdram_model: %s to closed bank %0d", cmd.name(), ba);
          end
        end
        CMD_REFRESH, CMD_NOP, CMD_DESELECT: ;
        default: $error("sdram_model: unsupported command %b", cmd);
      endcase
    end
  end

endmodule

`default_nettype wire

// File: sdram_ctrl/sdram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl import sdram_pkg::*; #(
  parameter int ROW_BITS         = 6,
  parameter int COL_BITS         = 5,
  parameter int CAS_LATENCY      = 3,
  parameter int REFRESH_INTERVAL = 64,
  parameter int INIT_WAIT        = 20
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   wb_cyc,
  input  logic                                   wb_stb,
  input  logic                                   wb_we,
  input  logic [BANK_BITS+ROW_BITS+COL_BITS-2:0] wb_adr,
  input  logic [BURST_LEN*DQ_BITS-1:0]           wb_dat_w,
  input  logic [BURST_LEN*DQ_BITS/8-1:0]         wb_sel,
  output logic [BURST_LEN*DQ_BITS-1:0]           wb_dat_r,
  output logic                                   wb_ack,
  output logic                                   sd_cke,
  output logic                                   sd_cs,
  output logic                                   sd_ras,
  output logic                                   sd_cas,
  output logic                                   sd_we,
  output logic [12:0]                            sd_a,
  output logic [BANK_BITS-1:0]                   sd_ba,
  output logic [DQ_BITS/8-1:0]                   sd_dqm,
  inout  wire  [DQ_BITS-1:0]                     sd_dq
);

  localparam int WAIT_W  = $clog2(INIT_WAIT + CAS_LATENCY + 4);
  localparam int REF_W   = $clog2(REFRESH_INTERVAL + 1);
  localparam int BL_CODE = $clog2(BURST_LEN);
  localparam int BEAT_W  = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;
  localparam int MASK_W  = DQ_BITS / 8;

  // sequential bursts, CL and BL taken from the parameters
  localparam logic [12:0] MODE_WORD =
    13'((CAS_LATENCY << MODE_CL_LSB) | (BL_CODE << MODE_BL_LSB));

  ctrl_state_e state;
  sdram_cmd_e  cmd;

  logic [WAIT_W-1:0] wait_cnt;    // init, tRCD and CAS wait
  logic [REF_W-1:0]  ref_cnt;
  logic              ref_pending;

  // request captured while idle
  logic                           we_q;
  logic [BANK_BITS-1:0]           bank_q;
  logic [ROW_BITS-1:0]            row_q;
  logic [COL_BITS-2:0]            colp_q;
  logic [BURST_LEN*DQ_BITS-1:0]   dat_q;
  logic [BURST_LEN*DQ_BITS/8-1:0] sel_q;

  logic [BEAT_W-1:0]  beat;
  logic               cap_busy;
  logic               cap_en;
  logic               dq_oe;
  logic [DQ_BITS-1:0] dq_out;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= ST_INIT_WAIT;
      wait_cnt <= WAIT_W'(INIT_WAIT - 1);
    end else begin
      if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
      case (state)
        ST_INIT_WAIT: begin
          if (wait_cnt == '0) state <= ST_INIT_PRE;
        end
        ST_INIT_PRE: begin
          state    <= ST_INIT_REF;
          wait_cnt <= WAIT_W'(3);   // REF, NOP, REF, NOP
        end
        ST_INIT_REF: begin
          if (wait_cnt == '0) state <= ST_INIT_MODE;
        end
        ST_INIT_MODE: state <= ST_IDLE;
        ST_IDLE: begin
          if (ref_pending) begin  // refresh beats a waiting request
            state    <= ST_REFRESH;
            wait_cnt <= WAIT_W'(1);
          end else if (wb_cyc && wb_stb) begin
            state <= ST_ACTIVATE;
          end
        end
        ST_ACTIVATE: begin
          state    <= ST_RCD;
          wait_cnt <= '0;           // single NOP covers tRCD
        end
        ST_RCD: begin
          if (wait_cnt == '0) state <= we_q ? ST_WRITE0 : ST_READ;
        end
        ST_WRITE0: state <= ST_WRITE1;
        ST_WRITE1: state <= ST_PRECHARGE;
        ST_READ: begin
          state    <= ST_CAS_WAIT;
          wait_cnt <= WAIT_W'(CAS_LATENCY - 2);
        end
        ST_CAS_WAIT: begin
          if (wait_cnt == '0) state <= ST_READ_CAP;
        end
        ST_READ_CAP:  state <= ST_PRECHARGE;
        ST_PRECHARGE: state <= ST_ACK;
        ST_REFRESH: begin
          if (wait_cnt == '0) state <= ST_IDLE;
        end
        ST_ACK:  state <= ST_IDLE;
        default: state <= ST_INIT_WAIT;
      endcase
    end
  end

  // free running refresh timer
  always_ff @(posedge clk) begin
    if (reset) begin
      ref_cnt     <= '0;
      ref_pending <= 1'b0;
    end else begin
      if (state == ST_IDLE && ref_pending) begin
        ref_pending <= 1'b0;
      end
      if (ref_cnt == REF_W'(REFRESH_INTERVAL - 1)) begin
        ref_cnt     <= '0;
        ref_pending <= 1'b1;
      end else begin
        ref_cnt <= ref_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE) begin
      we_q   <= wb_we;
      bank_q <= wb_adr[ROW_BITS+COL_BITS-1 +: BANK_BITS];
      row_q  <= wb_adr[COL_BITS-1 +: ROW_BITS];
      colp_q <= wb_adr[COL_BITS-2:0];
      dat_q  <= wb_dat_w;
      sel_q  <= wb_sel;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sd_cke <= 1'b1;   // no power down support
    end
  end

  // read capture, first beat lands at the end of ST_READ_CAP
  assign cap_en = (state == ST_READ_CAP) || cap_busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      cap_busy <= 1'b0;
    end else begin
      cap_busy <= cap_en && (beat != BEAT_W'(BURST_LEN - 1));
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_READ) begin
      beat <= '0;
    end else if (cap_en) begin
      beat <= beat + 1'b1;
    end
    if (cap_en) begin
      wb_dat_r[beat*DQ_BITS +: DQ_BITS] <= sd_dq;
    end
  end

  always_comb begin
    cmd    = CMD_NOP;
    sd_a   = '0;
    sd_ba  = '0;
    sd_dqm = '0;
    case (state)
      ST_INIT_PRE: begin
        cmd      = CMD_PRECHARGE;
        sd_a[10] = 1'b1;          // all banks
      end
      ST_INIT_REF, ST_REFRESH: begin
        if (wait_cnt[0]) cmd = CMD_REFRESH;
      end
      ST_INIT_MODE: begin
        cmd  = CMD_LOAD_MODE;
        sd_a = MODE_WORD;
      end
      ST_ACTIVATE: begin
        cmd                  = CMD_ACTIVE;
        sd_ba                = bank_q;
        sd_a[ROW_BITS-1:0]   = row_q;
      end
      ST_WRITE0: begin
        cmd                = CMD_WRITE;
        sd_ba              = bank_q;
        sd_a[COL_BITS-1:0] = {colp_q, 1'b0};
        sd_dqm             = ~sel_q[0 +: MASK_W];
      end
      ST_WRITE1: sd_dqm = ~sel_q[MASK_W +: MASK_W];   // second beat, no command
      ST_READ: begin
        cmd                = CMD_READ;
        sd_ba              = bank_q;
        sd_a[COL_BITS-1:0] = {colp_q, 1'b0};
      end
      ST_PRECHARGE: begin
        cmd   = CMD_PRECHARGE;    // a10 low, just this bank
        sd_ba = bank_q;
      end
      default: ;
    endcase
  end

  assign {sd_cs, sd_ras, sd_cas, sd_we} = cmd;

  assign dq_oe  = (state == ST_WRITE0) || (state == ST_WRITE1);
  assign dq_out = (state == ST_WRITE0) ? dat_q[0 +: DQ_BITS] : dat_q[DQ_BITS +: DQ_BITS];
  assign sd_dq  = dq_oe ? dq_out : 'z;

  assign wb_ack = (state == ST_ACK);

endmodule

`default_nettype wire

// File: common/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

  // {cs, ras, cas, we} as seen on the SDRAM command pins
  typedef enum logic [3:0] {
    CMD_LOAD_MODE = 4'b0000,
    CMD_REFRESH   = 4'b0001,
    CMD_PRECHARGE = 4'b0010,
    CMD_ACTIVE    = 4'b0011,
    CMD_WRITE     = 4'b0100,
    CMD_READ      = 4'b0101,
    CMD_NOP       = 4'b0111,
    CMD_DESELECT  = 4'b1111  // cs high, other pins don't care
  } sdram_cmd_e;

  typedef enum logic [3:0] {
    ST_INIT_WAIT,
    ST_INIT_PRE,
    ST_INIT_REF,
    ST_INIT_MODE,
    ST_IDLE,
    ST_ACTIVATE,
    ST_RCD,
    ST_WRITE0,
    ST_WRITE1,
    ST_READ,
    ST_CAS_WAIT,
    ST_READ_CAP,
    ST_PRECHARGE,
    ST_REFRESH,
    ST_ACK
  } ctrl_state_e;

  localparam int BANK_BITS = 2;   // four banks
  localparam int DQ_BITS   = 16;
  localparam int BURST_LEN = 2;   // two halfwords per bus word

  // mode register fields on the address pins
  localparam int MODE_CL_LSB = 4;
  localparam int MODE_BL_LSB = 0;

endpackage

`default_nettype wire
